//--- rtl/sram_pkg.sv
package sram_pkg;

  ////////////////////
  // widths

  localparam int sram_addr_w = 16;
  localparam int sram_data_w = 8;
  localparam int sram_meta_w = 4;
  localparam int sram_strb_w = 1;  // one strobe bit per byte lane

  typedef logic [sram_addr_w-1:0] sram_addr_t;
  typedef logic [sram_data_w-1:0] sram_data_t;
  typedef logic [sram_meta_w-1:0] sram_meta_t;
  typedef logic [sram_strb_w-1:0] sram_strb_t;

  ////////////////////
  // enums

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_skip  // write with no strobe bit set
  } sram_op_e;

  typedef enum logic [1:0] {
    idle,
    read_access,
    write_pulse,
    write_hold  // we_n back high with addr and data still held
  } sram_phase_e;

  ////////////////////
  // structs

  typedef struct packed {
    sram_addr_t addr;
    sram_meta_t meta;
    logic       last;
    logic       wr_en;
    sram_data_t wr_data;
    sram_strb_t wr_strb;
  } sram_cmd_t;

  typedef struct packed {
    sram_op_e   op;
    sram_addr_t addr;
    sram_data_t wr_data;
    sram_meta_t meta;
    logic       last;
  } sram_op_t;

  typedef struct packed {
    sram_meta_t meta;
    logic       last;
    sram_data_t rd_data;
  } sram_resp_t;

endpackage

//--- rtl/sram_cmd_decode.sv
module sram_cmd_decode (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                cmd_valid,
  input  sram_pkg::sram_cmd_t cmd,
  output logic                cmd_ready,

  output logic                op_valid,
  output sram_pkg::sram_op_t  op,
  input  logic                op_ready
);
  import sram_pkg::*;

  logic accept;

  // a write that enables no byte lane still needs a response
  function automatic sram_op_e classify(input sram_cmd_t c);
    sram_op_e kind;
    if (!c.wr_en) begin
      kind = op_read;
    end else if (|c.wr_strb) begin
      kind = op_write;
    end else begin
      kind = op_skip;
    end
    return kind;
  endfunction

  ////////////////////
  // handshake

  assign cmd_ready = !op_valid || op_ready;  // empty, or emptied this edge
  assign accept    = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
    end else if (accept) begin
      op_valid <= 1'b1;
    end else if (op_ready) begin
      op_valid <= 1'b0;
    end
  end

  ////////////////////
  // operation register

  always_ff @(posedge clk) begin
    if (accept) begin
      op.op      <= classify(cmd);
      op.addr    <= cmd.addr;
      op.wr_data <= cmd.wr_data;
      op.meta    <= cmd.meta;  // tag and last ride along untouched
      op.last    <= cmd.last;
    end
  end

endmodule

//--- rtl/sram_io_execute.sv
module sram_io_execute (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 op_valid,
  input  sram_pkg::sram_op_t   op,
  output logic                 op_ready,

  output logic                 res_valid,
  output sram_pkg::sram_resp_t res,
  input  logic                 res_ready,

  output sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::sram_data_t sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);
  import sram_pkg::*;

  sram_phase_e phase;
  sram_data_t  wr_data_q;
  sram_meta_t  meta_q;
  logic        last_q;
  logic        hold_free;
  logic        start;

  // response holder is free if empty or drained on this edge
  assign hold_free = !res_valid || res_ready;
  assign op_ready  = (phase == idle) && hold_free;
  assign start     = op_valid && op_ready;

  // bus is ours only during the write pulse
  assign sram_data = sram_we_n ? 'z : wr_data_q;

  ////////////////////
  // access FSM

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase     <= idle;
      res_valid <= 1'b0;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b0;  // chip stays selected while oe_n/we_n gate access
    end else begin
      if (res_valid && res_ready) begin
        res_valid <= 1'b0;
      end
      case (phase)
        idle: begin
          if (start) begin
            case (op.op)
              op_read: begin
                sram_oe_n <= 1'b0;
                phase     <= read_access;
              end
              op_write: begin
                sram_we_n <= 1'b0;
                phase     <= write_pulse;
              end
              default: res_valid <= 1'b1;  // a skip has no pin activity
            endcase
          end
        end
        read_access: begin
          sram_oe_n <= 1'b1;
          res_valid <= 1'b1;
          phase     <= idle;
        end
        write_pulse: begin
          sram_we_n <= 1'b1;
          phase     <= write_hold;
        end
        write_hold: begin
          res_valid <= 1'b1;
          phase     <= idle;
        end
        default: phase <= idle;
      endcase
    end
  end

  ////////////////////
  // address, data and response

  always_ff @(posedge clk) begin
    if (start) begin
      sram_addr <= op.addr;
      wr_data_q <= op.wr_data;
      meta_q    <= op.meta;
      last_q    <= op.last;
    end
    if (start && op.op == op_skip) begin
      res <= '{meta: op.meta, last: op.last, rd_data: '0};
    end
    if (phase == read_access) begin
      res <= '{meta: meta_q, last: last_q, rd_data: sram_data};  // sampled at end of oe_n
    end
    if (phase == write_hold) begin
      res <= '{meta: meta_q, last: last_q, rd_data: '0};
    end
  end

endmodule

//--- rtl/sram_resp_result.sv
module sram_resp_result (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 res_valid,
  input  sram_pkg::sram_resp_t res,
  output logic                 res_ready,

  output logic                 resp_valid,
  output sram_pkg::sram_resp_t resp,
  input  logic                 resp_ready
);
  import sram_pkg::*;

  sram_resp_t mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  ////////////////////
  // two-entry FIFO

  assign res_ready  = (count != 2'd2);  // only stalls execute when full
  assign resp_valid = (count != 2'd0);
  assign resp       = mem[rd_ptr];      // head stays put until popped

  assign push = res_valid && res_ready;
  assign pop  = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= res;
    end
  end

endmodule

//--- rtl/sram_io_if.sv
module sram_io_if (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 cmd_valid,
  input  sram_pkg::sram_cmd_t  cmd,
  output logic                 cmd_ready,

  output logic                 resp_valid,
  output sram_pkg::sram_resp_t resp,
  input  logic                 resp_ready,

  output sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::sram_data_t sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);
  import sram_pkg::*;

  logic       op_valid;
  sram_op_t   op;
  logic       op_ready;

  logic       res_valid;
  sram_resp_t res;
  logic       res_ready;

  ////////////////////
  // decode

  sram_cmd_decode decode_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .cmd_ready(cmd_ready),
    .op_valid (op_valid),
    .op       (op),
    .op_ready (op_ready)
  );

  ////////////////////
  // execute

  sram_io_execute execute_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_valid (op_valid),
    .op       (op),
    .op_ready (op_ready),
    .res_valid(res_valid),
    .res      (res),
    .res_ready(res_ready),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n)
  );

  ////////////////////
  // result

  sram_resp_result result_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res       (res),
    .res_ready (res_ready),
    .resp_valid(resp_valid),
    .resp      (resp),
    .resp_ready(resp_ready)
  );

endmodule

//--- dv/sram_async_model.sv
module sram_async_model (
  input  logic                 rst_n,
  input  sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::sram_data_t sram_data,
  input  logic                 sram_we_n,
  input  logic                 sram_oe_n,
  input  logic                 sram_ce_n,
  output logic                 uninit_read
);
  timeunit 1ns;
  timeprecision 1ps;
  import sram_pkg::*;

  sram_data_t mem [sram_addr_t];  // only written cells exist
  sram_data_t rd_val;
  logic       rd_en;
  logic       oe_was_low = 1'b0;
  logic       flag = 1'b0;

  assign uninit_read = flag;

  ////////////////////
  // read side

  assign rd_en     = (sram_ce_n == 1'b0) && (sram_oe_n == 1'b0);
  assign sram_data = rd_en ? rd_val : 'z;

  always @(sram_addr or sram_oe_n or sram_ce_n or sram_we_n) begin
    if (mem.exists(sram_addr)) begin
      rd_val = mem[sram_addr];
    end else begin
      rd_val = 'x;
    end
  end

  // address is still held when oe_n returns high
  always @(sram_oe_n) begin
    if (rst_n && oe_was_low && sram_oe_n && !sram_ce_n && !mem.exists(sram_addr)) begin
      $display("read of unwritten SRAM address %h at %0t", sram_addr, $time);
      flag = 1'b1;
    end
    oe_was_low = !sram_oe_n;
  end

  ////////////////////
  // write side

  // the cell follows the bus while we_n is low
  always @(sram_we_n or sram_ce_n or sram_addr or sram_data) begin
    if (rst_n && sram_ce_n == 1'b0 && sram_we_n == 1'b0) begin
      mem[sram_addr] = sram_data;
    end
  end

endmodule

//--- dv/sram_io_if_tb.sv
module sram_io_if_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sram_pkg::*;

  localparam int clk_period = 100;
  localparam int num_cmds   = 81;  // all commands issued by the tests below

  typedef struct packed {
    sram_resp_t resp;
    logic       is_read;
  } exp_resp_t;

  logic            clk;
  logic            rst_n;
  logic            cmd_valid;
  sram_cmd_t       cmd;
  logic            cmd_ready;
  logic            resp_valid;
  sram_resp_t      resp;
  logic            resp_ready;
  sram_addr_t      sram_addr;
  wire sram_data_t sram_data;
  logic            sram_we_n;
  logic            sram_oe_n;
  logic            sram_ce_n;
  logic            uninit_read;

  sram_data_t  ref_mem [sram_addr_t];
  exp_resp_t   exp_q [$];
  sram_addr_t  written_q [$];
  logic [31:0] rng_state;
  int          errors;
  int          resp_count;

  sram_io_if sram_io_if_inst (.*);

  sram_async_model model_inst (
    .rst_n      (rst_n),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n),
    .uninit_read(uninit_read)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(time'(num_cmds * 20 + 200) * time'(clk_period));
    $display("timeout: the tests did not complete within the cycle budget");
    $display("Finished with errors");
    $finish;
  end

  ////////////////////
  // helpers

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic sram_cmd_t make_cmd(input logic wr, input sram_addr_t a,
                                         input sram_data_t d, input sram_strb_t s,
                                         input sram_meta_t m, input logic l);
    return '{addr: a, meta: m, last: l, wr_en: wr, wr_data: d, wr_strb: s};
  endfunction

  function automatic void check_resp(input sram_resp_t got);
    exp_resp_t head;
    resp_count++;
    if (exp_q.size() == 0) begin
      $display("unexpected response with meta %h at %0t", got.meta, $time);
      errors++;
    end else begin
      head = exp_q.pop_front();
      if (got.meta != head.resp.meta || got.last != head.resp.last) begin
        $display("mismatch at %0t: meta/last %h/%b, expected %h/%b", $time,
                 got.meta, got.last, head.resp.meta, head.resp.last);
        errors++;
      end
      if (head.is_read && got.rd_data != head.resp.rd_data) begin
        $display("mismatch at %0t: rd_data %h for meta %h, expected %h", $time,
                 got.rd_data, got.meta, head.resp.rd_data);
        errors++;
      end
    end
  endfunction

  // responses are sampled mid-cycle and transfer on the next edge
  always @(negedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      check_resp(resp);
    end
  end

  // called 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_cmd(input sram_cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic issue(input sram_cmd_t c);
    exp_resp_t e;
    e.resp    = '{meta: c.meta, last: c.last, rd_data: '0};
    e.is_read = !c.wr_en;
    if (!c.wr_en) begin
      e.resp.rd_data = ref_mem[c.addr];
    end else if (c.wr_strb[0]) begin
      if (!ref_mem.exists(c.addr)) written_q.push_back(c.addr);
      ref_mem[c.addr] = c.wr_data;
    end
    exp_q.push_back(e);
    send_cmd(c);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  ////////////////////
  // tests

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    if (sram_ce_n !== 1'b0 || sram_oe_n !== 1'b1 || sram_we_n !== 1'b1) begin
      $display("mismatch at %0t: SRAM strobes ce/oe/we %b%b%b, expected 011", $time,
               sram_ce_n, sram_oe_n, sram_we_n);
      errors++;
    end
    if (resp_valid !== 1'b0) begin
      $display("mismatch at %0t: resp_valid high after reset", $time);
      errors++;
    end
    if (cmd_ready !== 1'b1) begin
      $display("mismatch at %0t: cmd_ready low after reset", $time);
      errors++;
    end
    report_test("reset_state", e0);
  endtask

  task automatic write_then_read();
    int e0;
    e0 = errors;
    issue(make_cmd(1'b1, 16'hA000, 8'hD0, 1'b1, 4'hB, 1'b0));
    issue(make_cmd(1'b0, 16'hA000, 8'h00, 1'b0, 4'hC, 1'b1));
    wait_drained();
    report_test("write_then_read", e0);
  endtask

  task automatic random_mix();
    int          e0;
    int          n0;
    int          idx;
    logic [31:0] r;
    e0 = errors;
    n0 = resp_count;
    for (int i = 0; i < 64; i++) begin
      r = next_random();
      if (r[0] && written_q.size() != 0) begin
        idx = int'(r[30:16]) % written_q.size();  // only addresses already written
        issue(make_cmd(1'b0, written_q[idx], '0, '0, r[7:4], r[8]));
      end else begin
        issue(make_cmd(1'b1, r[31:16], r[15:8], 1'b1, r[7:4], r[8]));
      end
    end
    wait_drained();
    if (resp_count - n0 != 64) begin
      $display("random_mix got %0d responses for 64 commands", resp_count - n0);
      errors++;
    end
    report_test("random_mix", e0);
  endtask

  task automatic zero_strobe_write();
    int   e0;
    logic we_low;
    e0     = errors;
    we_low = 1'b0;
    issue(make_cmd(1'b1, 16'h5A5A, 8'h3C, 1'b1, 4'h1, 1'b0));
    wait_drained();
    issue(make_cmd(1'b1, 16'h5A5A, 8'hC3, 1'b0, 4'h2, 1'b0));
    while (exp_q.size() != 0) begin
      @(negedge clk);
      if (sram_we_n !== 1'b1) we_low = 1'b1;
    end
    @(posedge clk);
    #1;
    if (we_low) begin
      $display("sram_we_n was pulsed by a write with no strobe bit set");
      errors++;
    end
    issue(make_cmd(1'b0, 16'h5A5A, 8'h00, 1'b0, 4'h3, 1'b1));  // old value expected
    wait_drained();
    report_test("zero_strobe_write", e0);
  endtask

  task automatic back_pressure();
    int         e0;
    sram_resp_t held;
    logic       moved;
    e0         = errors;
    moved      = 1'b0;
    resp_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 5; i++) begin
          issue(make_cmd(1'b1, sram_addr_t'(32'h1000 + i), sram_data_t'(32'h40 + i), 1'b1,
                         sram_meta_t'(i), 1'b0));
        end
        for (int i = 0; i < 5; i++) begin
          issue(make_cmd(1'b0, sram_addr_t'(32'h1000 + i), '0, '0,
                         sram_meta_t'(32'h8 + i), i == 4));
        end
      end
      begin
        @(negedge clk);
        while (!resp_valid) @(negedge clk);
        held = resp;
        repeat (12) begin  // hold the stall while the pipeline fills
          @(negedge clk);
          if (resp != held || !resp_valid) moved = 1'b1;
        end
        if (cmd_ready) begin
          $display("cmd_ready stayed high with resp_ready held low");
          errors++;
        end
        if (moved) begin
          $display("mismatch at %0t: resp changed while resp_ready was low", $time);
          errors++;
        end
        @(posedge clk);
        #1;
        resp_ready = 1'b1;
      end
    join
    wait_drained();
    report_test("back_pressure", e0);
  endtask

  task automatic access_latency();
    int  e0;
    int  cycles;
    time t0;
    e0 = errors;
    for (int k = 0; k < 2; k++) begin
      if (k == 0) begin
        issue(make_cmd(1'b1, 16'h0042, 8'h99, 1'b1, 4'hE, 1'b0));
      end else begin
        issue(make_cmd(1'b0, 16'h0042, 8'h00, 1'b0, 4'hF, 1'b1));
      end
      t0 = $time - 1;  // acceptance edge
      @(negedge clk);
      while (!resp_valid) begin
        if ((!sram_we_n || !sram_oe_n) && sram_addr !== 16'h0042) begin
          $display("mismatch at %0t: sram_addr %h during the access, expected 0042", $time,
                   sram_addr);
          errors++;
        end
        if (!sram_we_n && sram_data !== 8'h99) begin
          $display("mismatch at %0t: sram_data %h during the write pulse, expected 99", $time,
                   sram_data);
          errors++;
        end
        @(negedge clk);
      end
      cycles = int'(($time - t0 - time'(clk_period / 2)) / time'(clk_period));
      if (cycles != (k == 0 ? 4 : 3)) begin
        $display("mismatch at %0t: %s latency %0d cycles, expected %0d", $time,
                 k == 0 ? "write" : "read", cycles, k == 0 ? 4 : 3);
        errors++;
      end
      wait_drained();
    end
    report_test("access_latency", e0);
  endtask

  ////////////////////
  // main sequence

  initial begin
    $timeformat(-9, 0, " ns", 0);
    errors     = 0;
    resp_count = 0;
    rng_state  = 32'ha53c_cd47;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    resp_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_reset_state();
    write_then_read();
    random_mix();
    zero_strobe_write();
    back_pressure();
    access_latency();

    if (uninit_read) begin
      $display("the SRAM model saw a read of an address never written");
      errors++;
    end
    $display("summary: %0d responses checked, %0d errors", resp_count, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- build.f
rtl/sram_pkg.sv
rtl/sram_cmd_decode.sv
rtl/sram_io_execute.sv
rtl/sram_resp_result.sv
rtl/sram_io_if.sv
dv/sram_async_model.sv
dv/sram_io_if_tb.sv

//--- Makefile
# Verilator simulation of the SRAM bridge testbench

VERILATOR ?= verilator
TOP       ?= sram_io_if_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
